/* chipRamPkg.sv */
package chipRamPkg;

    ////////////////////
    // SDRAM commands
    ////////////////////

    // Bit order is CS, RAS, CAS, WE and all four are active low
    typedef enum logic [3:0] {
        cmdNop          = 4'b1111,
        cmdPrecharge    = 4'b0010,
        cmdBankActivate = 4'b0011,
        cmdRead         = 4'b0101,
        cmdWrite        = 4'b0100,
        cmdAutoRefresh  = 4'b0001,
        cmdModeRegister = 4'b0000
    } sdramCmdT;

    // Sequencer top level states
    typedef enum logic [1:0] {
        stInit,
        stIdle,
        stRefresh,
        stAccess
    } seqStateT;

    // Kind of cycle handed from the arbiter to the sequencer
    // cycNone between grants
    typedef enum logic [1:0] {
        cycNone,
        cycRefresh,
        cycDma,
        cycCpu
    } cycleKindT;

    ////////////////////
    // Fixed SDRAM words
    ////////////////////

    // CAS latency 2, sequential burst of 4
    localparam logic [10:0] modeRegValue = 11'h022;

    // A10 high selects all banks on precharge
    localparam logic [10:0] prechargeAllAddr = 11'h400;

endpackage

/* refreshTimer.sv */
`timescale 1ns/100ps

module refreshTimer #(
    parameter int refreshInterval = 27
) (
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic refreshIssued,
    output logic refreshDue
);

    // Interval as a counter value
    localparam logic [7:0] intervalCount = 8'(refreshInterval);

    // Cycles since the last auto-refresh
    logic [7:0] count;

    ////////////////////
    // Cycle counter
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            count <= '0;
        end else begin
            if (refreshIssued) begin
                // Restart once the SDRAM has seen the refresh
                count <= '0;
            end else if (count != 8'hFF) begin
                // Stops at full scale so a long access cannot wrap it
                count <= count + 8'd1;
            end
        end
    end

    // Level request, stays up until the refresh is issued
    assign refreshDue = (count >= intervalCount);

endmodule

/* agnusCapture.sv */
`timescale 1ns/100ps

module agnusCapture (
    input  logic       C1,
    input  logic       REFRESH_RST,
    input  logic       ras0N,
    input  logic       ras1N,
    input  logic       caslN,
    input  logic       casuN,
    input  logic       dbrN,
    input  logic       aweN,
    input  logic [9:0] dra,
    input  logic       tsN,
    input  logic       ramSpaceN,
    input  logic       rnw,
    input  logic       dmaAccept,
    input  logic       cpuAccept,
    output logic       dmaPending,
    output logic [9:0] dmaRow,
    output logic [9:0] dmaCol,
    output logic       dmaWrite,
    output logic       cpuPending,
    output logic       cpuWrite,
    output logic       dbrIdle
);

    // Either RAS line or either CAS byte strobe counts as one strobe
    logic rasAnyN;
    logic casAnyN;
    // Stage 0 and 1 synchronize, stage 2 keeps the previous level
    logic [2:0] rasSync;
    logic [2:0] casSync;
    logic [2:0] dbrSync;
    logic [1:0] ras0Sync;
    logic rasFall;
    logic casFall;
    logic cpuStart;

    assign rasAnyN = ras0N & ras1N;
    assign casAnyN = caslN & casuN;

    ////////////////////
    // Synchronizers
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            rasSync  <= '1;
            casSync  <= '1;
            dbrSync  <= '1;
            ras0Sync <= '1;
        end else begin
            rasSync  <= {rasSync[1:0], rasAnyN};
            casSync  <= {casSync[1:0], casAnyN};
            dbrSync  <= {dbrSync[1:0], dbrN};
            ras0Sync <= {ras0Sync[0], ras0N};
        end
    end

    assign rasFall = rasSync[2] & ~rasSync[1];
    assign casFall = casSync[2] & ~casSync[1];

    // Agnus has let go of the bus for two samples in a row
    assign dbrIdle = dbrSync[2] & dbrSync[1];

    // CPU transfer start inside chip RAM space
    assign cpuStart = ~tsN & ~ramSpaceN;

    ////////////////////
    // Address latches
    ////////////////////

    always_ff @(posedge C1) begin
        // Top row bit records which RAS line fell, 8372A style
        if (rasFall) begin
            dmaRow <= {ras0Sync[1], dra[8:0]};
        end
        if (casFall) begin
            dmaCol   <= dra;
            dmaWrite <= ~aweN;
        end
        if (cpuStart) begin
            cpuWrite <= ~rnw;
        end
    end

    // Pending flags, a new request merges into one already waiting
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            dmaPending <= 1'b0;
            cpuPending <= 1'b0;
        end else begin
            dmaPending <= casFall | (dmaPending & ~dmaAccept);
            cpuPending <= cpuStart | (cpuPending & ~cpuAccept);
        end
    end

endmodule

/* accessArbiter.sv */
`timescale 1ns/100ps

module accessArbiter import chipRamPkg::*; (
    input  logic        C1,
    input  logic        REFRESH_RST,
    input  logic        seqIdle,
    input  logic        refreshDue,
    input  logic        dmaPending,
    input  logic [9:0]  dmaRow,
    input  logic [9:0]  dmaCol,
    input  logic        dmaWrite,
    input  logic        cpuPending,
    input  logic        cpuWrite,
    input  logic        dbrIdle,
    input  logic [20:1] cpuAddr,
    output cycleKindT   grantKind,
    output logic [10:0] rowAddr,
    output logic [10:0] colAddr,
    output logic        grantWrite,
    output logic        grantDben,
    output logic        dmaAccept,
    output logic        cpuAccept
);

    cycleKindT nextKind;

    ////////////////////
    // Winner selection
    ////////////////////

    // Refresh, then DMA, then CPU
    // No new grant while the last one is still on its way
    always_comb begin
        nextKind = cycNone;
        if (seqIdle && (grantKind == cycNone)) begin
            if (refreshDue) begin
                nextKind = cycRefresh;
            end else if (dmaPending) begin
                nextKind = cycDma;
            end else if (cpuPending && dbrIdle) begin
                // CPU only gets the RAM once Agnus has released it
                nextKind = cycCpu;
            end
        end
    end

    // Grant strobe and accept pulses, one cycle each
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            grantKind <= cycNone;
            dmaAccept <= 1'b0;
            cpuAccept <= 1'b0;
        end else begin
            grantKind <= nextKind;
            dmaAccept <= (nextKind == cycDma);
            cpuAccept <= (nextKind == cycCpu);
        end
    end

    ////////////////////
    // Address map
    ////////////////////

    always_ff @(posedge C1) begin
        case (nextKind)
            cycDma: begin
                // Row bit 9 holds the RAS line, column drops DRA0
                rowAddr    <= {1'b0, dmaRow[9], dmaRow[8:0]};
                colAddr    <= {3'b000, dmaCol[8:1]};
                grantWrite <= dmaWrite;
                // DRA0 of the column steers the data buffer
                grantDben  <= ~dmaCol[0];
            end
            cycCpu: begin
                // 1 MB map, same split as the Agnus multiplexer
                rowAddr    <= {1'b0, cpuAddr[19], cpuAddr[17:9]};
                colAddr    <= {3'b000, cpuAddr[18], cpuAddr[8:2]};
                grantWrite <= cpuWrite;
                grantDben  <= 1'b1;
            end
            default: begin
                // Refresh carries no address, keep the last one
            end
        endcase
    end

endmodule

/* sdramSequencer.sv */
`timescale 1ns/100ps

module sdramSequencer import chipRamPkg::*; (
    input  logic        C1,
    input  logic        REFRESH_RST,
    input  cycleKindT   grantKind,
    input  logic [10:0] rowAddr,
    input  logic [10:0] colAddr,
    input  logic        grantWrite,
    input  logic        grantDben,
    output logic        seqIdle,
    output logic        refreshIssued,
    output logic        crcsN,
    output logic        rasN,
    output logic        casN,
    output logic        weN,
    output logic [10:0] cma,
    output logic        cpuTack,
    output logic        cpuCycle,
    output logic        dmaCycle,
    output logic        dbenN,
    output logic        dbdir,
    output logic        clkEn
);

    seqStateT state;
    // Step within the current sequence
    logic [3:0] step;
    sdramCmdT cmd;

    // Grant held for the length of the access
    logic [10:0] rowQ;
    logic [10:0] colQ;
    logic writeQ;
    logic dbenQ;
    logic cpuQ;

    // Command register drives the pins directly
    assign {crcsN, rasN, casN, weN} = cmd;

    assign seqIdle = (state == stIdle);

    always_ff @(posedge C1) begin
        if ((state == stIdle) && (grantKind != cycNone)) begin
            rowQ   <= rowAddr;
            colQ   <= colAddr;
            writeQ <= grantWrite;
            dbenQ  <= grantDben;
            cpuQ   <= (grantKind == cycCpu);
        end
    end

    ////////////////////
    // Main FSM
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            state         <= stInit;
            step          <= '0;
            cmd           <= cmdNop;
            cma           <= '0;
            refreshIssued <= 1'b0;
            cpuTack       <= 1'b0;
            cpuCycle      <= 1'b0;
            dmaCycle      <= 1'b0;
            dbenN         <= 1'b1;
            dbdir         <= 1'b1;
            clkEn         <= 1'b1;
        end else begin
            // Nop unless a step below says otherwise
            cmd           <= cmdNop;
            refreshIssued <= 1'b0;

            case (state)
                stInit: begin
                    step <= step + 4'd1;
                    // Power-up order: precharge all, mode word, two refreshes
                    case (step)
                        4'd0: begin
                            cmd <= cmdPrecharge;
                            cma <= prechargeAllAddr;
                        end
                        4'd2: begin
                            cmd <= cmdModeRegister;
                            cma <= modeRegValue;
                        end
                        4'd5, 4'd9: begin
                            cmd           <= cmdAutoRefresh;
                            refreshIssued <= 1'b1;
                        end
                        4'd13: begin
                            state <= stIdle;
                            step  <= '0;
                        end
                        default: begin
                        end
                    endcase
                end

                stIdle: begin
                    // Grant seen here, pins move on the next edge
                    if (grantKind != cycNone) begin
                        step  <= '0;
                        state <= (grantKind == cycRefresh) ? stRefresh : stAccess;
                    end
                end

                stRefresh: begin
                    step <= step + 4'd1;
                    case (step)
                        4'd0: begin
                            cmd           <= cmdAutoRefresh;
                            refreshIssued <= 1'b1;
                        end
                        // tRC covered by three nops
                        4'd3: begin
                            state <= stIdle;
                        end
                        default: begin
                        end
                    endcase
                end

                stAccess: begin
                    step <= step + 4'd1;
                    case (step)
                        4'd0: begin
                            cmd      <= cmdBankActivate;
                            cma      <= rowQ;
                            cpuCycle <= cpuQ;
                            dmaCycle <= ~cpuQ;
                            dbenN    <= dbenQ;
                            dbdir    <= ~writeQ;
                        end
                        4'd1: begin
                            // Early acknowledge, write data already on the bus
                            cpuTack <= cpuQ & writeQ;
                        end
                        4'd2: begin
                            // Two cycles after activate for tRCD
                            cpuTack <= 1'b0;
                            cmd     <= writeQ ? cmdWrite : cmdRead;
                            cma     <= colQ;
                        end
                        4'd3: begin
                            cmd <= cmdPrecharge;
                            cma <= prechargeAllAddr;
                        end
                        4'd5: begin
                            // Read data valid after CAS latency 2
                            cpuTack <= cpuQ & ~writeQ;
                            // Freeze the SDRAM clock so read data stays put
                            clkEn   <= writeQ;
                        end
                        4'd6: begin
                            cpuTack <= 1'b0;
                            clkEn   <= 1'b1;
                        end
                        4'd7: begin
                            cpuCycle <= 1'b0;
                            dmaCycle <= 1'b0;
                            dbenN    <= 1'b1;
                            state    <= stIdle;
                        end
                        default: begin
                        end
                    endcase
                end

                default: begin
                    state <= stInit;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

/* chipRamTop.sv */
`timescale 1ns/100ps

module chipRamTop import chipRamPkg::*; #(
    parameter int refreshInterval = 27
) (
    input  logic        C1,
    input  logic        REFRESH_RST,
    // CPU side
    input  logic        tsN,
    input  logic        ramSpaceN,
    input  logic        rnw,
    input  logic [20:1] cpuAddr,
    // Agnus side
    input  logic        ras0N,
    input  logic        ras1N,
    input  logic        caslN,
    input  logic        casuN,
    input  logic        dbrN,
    input  logic        aweN,
    input  logic [9:0]  dra,
    // SDRAM and bus control pins
    output logic        crcsN,
    output logic        rasN,
    output logic        casN,
    output logic        weN,
    output logic [10:0] cma,
    output logic        cpuTack,
    output logic        cpuCycle,
    output logic        dmaCycle,
    output logic        dbenN,
    output logic        dbdir,
    output logic        clkEn
);

    // Capture to arbiter
    logic       dmaPending;
    logic [9:0] dmaRow;
    logic [9:0] dmaCol;
    logic       dmaWrite;
    logic       cpuPending;
    logic       cpuWrite;
    logic       dbrIdle;
    logic       dmaAccept;
    logic       cpuAccept;

    // Arbiter to sequencer
    cycleKindT   grantKind;
    logic [10:0] rowAddr;
    logic [10:0] colAddr;
    logic        grantWrite;
    logic        grantDben;
    logic        seqIdle;

    // Refresh loop
    logic refreshDue;
    logic refreshIssued;

    refreshTimer #(
        .refreshInterval(refreshInterval)
    ) uRefreshTimer (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .refreshIssued(refreshIssued),
        .refreshDue   (refreshDue)
    );

    agnusCapture uAgnusCapture (
        .C1         (C1),
        .REFRESH_RST(REFRESH_RST),
        .ras0N      (ras0N),
        .ras1N      (ras1N),
        .caslN      (caslN),
        .casuN      (casuN),
        .dbrN       (dbrN),
        .aweN       (aweN),
        .dra        (dra),
        .tsN        (tsN),
        .ramSpaceN  (ramSpaceN),
        .rnw        (rnw),
        .dmaAccept  (dmaAccept),
        .cpuAccept  (cpuAccept),
        .dmaPending (dmaPending),
        .dmaRow     (dmaRow),
        .dmaCol     (dmaCol),
        .dmaWrite   (dmaWrite),
        .cpuPending (cpuPending),
        .cpuWrite   (cpuWrite),
        .dbrIdle    (dbrIdle)
    );

    accessArbiter uAccessArbiter (
        .C1         (C1),
        .REFRESH_RST(REFRESH_RST),
        .seqIdle    (seqIdle),
        .refreshDue (refreshDue),
        .dmaPending (dmaPending),
        .dmaRow     (dmaRow),
        .dmaCol     (dmaCol),
        .dmaWrite   (dmaWrite),
        .cpuPending (cpuPending),
        .cpuWrite   (cpuWrite),
        .dbrIdle    (dbrIdle),
        .cpuAddr    (cpuAddr),
        .grantKind  (grantKind),
        .rowAddr    (rowAddr),
        .colAddr    (colAddr),
        .grantWrite (grantWrite),
        .grantDben  (grantDben),
        .dmaAccept  (dmaAccept),
        .cpuAccept  (cpuAccept)
    );

    sdramSequencer uSdramSequencer (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .grantKind    (grantKind),
        .rowAddr      (rowAddr),
        .colAddr      (colAddr),
        .grantWrite   (grantWrite),
        .grantDben    (grantDben),
        .seqIdle      (seqIdle),
        .refreshIssued(refreshIssued),
        .crcsN        (crcsN),
        .rasN         (rasN),
        .casN         (casN),
        .weN          (weN),
        .cma          (cma),
        .cpuTack      (cpuTack),
        .cpuCycle     (cpuCycle),
        .dmaCycle     (dmaCycle),
        .dbenN        (dbenN),
        .dbdir        (dbdir),
        .clkEn        (clkEn)
    );

endmodule

/* chipRam_assertions.sv */
`timescale 1ns/100ps

module chipRam_assertions import chipRamPkg::*; (
    input logic     C1,
    input logic     REFRESH_RST,
    input seqStateT state,
    input sdramCmdT cmd,
    input logic     cpuTack
);

    // Set once the power-up precharge has gone out
    logic sawPrecharge;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            sawPrecharge <= 1'b0;
        end else if (cmd == cmdPrecharge) begin
            sawPrecharge <= 1'b1;
        end
    end

    ////////////////////
    // Command rules
    ////////////////////

    // Acknowledge is a single cycle strobe
    tackSingle: assert property (@(posedge C1) disable iff (REFRESH_RST)
        cpuTack |=> !cpuTack)
        else $error("cpuTack held high for two cycles");

    // tRCD of two cycles between activate and CAS
    casAfterActivate: assert property (@(posedge C1) disable iff (REFRESH_RST)
        (cmd == cmdRead || cmd == cmdWrite) |-> ($past(cmd, 2) == cmdBankActivate))
        else $error("read or write without activate two cycles earlier");

    // Only nops until the first precharge of power-up
    quietInit: assert property (@(posedge C1) disable iff (REFRESH_RST)
        (state == stInit && !sawPrecharge) |-> (cmd == cmdNop || cmd == cmdPrecharge))
        else $error("command issued before the power-up precharge");

endmodule

bind sdramSequencer chipRam_assertions uAssertions (
    .C1         (C1),
    .REFRESH_RST(REFRESH_RST),
    .state      (state),
    .cmd        (cmd),
    .cpuTack    (cpuTack)
);

/* tb_chipRam.sv */
`timescale 1ns/100ps

module tb_chipRam import chipRamPkg::*; ();

    localparam int refreshInterval = 40;
    localparam int accessTimeout   = 200;
    // Values the SDRAM must see during power-up and precharge
    localparam logic [10:0] expPrechargeAddr = 11'h400;
    localparam logic [10:0] expModeWord      = 11'h022;

    logic        C1;
    logic        REFRESH_RST;
    logic        tsN;
    logic        ramSpaceN;
    logic        rnw;
    logic [20:1] cpuAddr;
    logic        ras0N;
    logic        ras1N;
    logic        caslN;
    logic        casuN;
    logic        dbrN;
    logic        aweN;
    logic [9:0]  dra;
    logic        crcsN;
    logic        rasN;
    logic        casN;
    logic        weN;
    logic [10:0] cma;
    logic        cpuTack;
    logic        cpuCycle;
    logic        dmaCycle;
    logic        dbenN;
    logic        dbdir;
    logic        clkEn;

    int valueErrors = 0;
    int timeoutErrors = 0;
    int cycleCount = 0;

    chipRamTop #(
        .refreshInterval(refreshInterval)
    ) dut (
        .C1(C1), .REFRESH_RST(REFRESH_RST),
        .tsN(tsN), .ramSpaceN(ramSpaceN), .rnw(rnw), .cpuAddr(cpuAddr),
        .ras0N(ras0N), .ras1N(ras1N), .caslN(caslN), .casuN(casuN),
        .dbrN(dbrN), .aweN(aweN), .dra(dra),
        .crcsN(crcsN), .rasN(rasN), .casN(casN), .weN(weN), .cma(cma),
        .cpuTack(cpuTack), .cpuCycle(cpuCycle), .dmaCycle(dmaCycle),
        .dbenN(dbenN), .dbdir(dbdir), .clkEn(clkEn)
    );

    initial begin
        C1 = 1'b0;
        forever #5 C1 = ~C1;
    end

    // Cycle stamp for gap measurements
    always @(posedge C1) begin
        cycleCount <= cycleCount + 1;
    end

    ////////////////////
    // Pin decoding and compares
    ////////////////////

    // JEDEC truth table, CS high is a deselect and acts as nop
    function automatic sdramCmdT currentCmd();
        sdramCmdT result;
        result = cmdNop;
        casez ({crcsN, rasN, casN, weN})
            4'b1???: result = cmdNop;
            4'b0111: result = cmdNop;
            4'b0010: result = cmdPrecharge;
            4'b0011: result = cmdBankActivate;
            4'b0101: result = cmdRead;
            4'b0100: result = cmdWrite;
            4'b0001: result = cmdAutoRefresh;
            4'b0000: result = cmdModeRegister;
            default: begin
                $display("Command pins show an undefined pattern at %0t", $time);
                valueErrors++;
            end
        endcase
        return result;
    endfunction

    task automatic checkCmd(input string what, input sdramCmdT actual, input sdramCmdT expected);
        if (actual !== expected) begin
            $display("FAILED %0t: %s expected %s got %s", $time, what, expected.name(),
                     actual.name());
            valueErrors++;
        end
    endtask

    task automatic checkAddr(input string what, input logic [10:0] actual,
                             input logic [10:0] expected);
        if (actual !== expected) begin
            $display("FAILED %0t: %s expected %h got %h", $time, what, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkBit(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %0t: %s expected %b got %b", $time, what, expected, actual);
            valueErrors++;
        end
    endtask

    // Samples at the falling edge, well clear of the registered outputs
    task automatic waitCmd(input sdramCmdT wanted, input int limit, output bit found);
        int waited;
        waited = 0;
        found = 1'b0;
        while (!found && waited < limit) begin
            @(negedge C1);
            waited++;
            if (currentCmd() == wanted) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Timeout: no %s command within %0d cycles", wanted.name(), limit);
            timeoutErrors++;
        end
    endtask

    ////////////////////
    // Stimulus and expected maps
    ////////////////////

    // CPU address bits 20 to 1 split as row and column
    function automatic logic [10:0] cpuRowOf(input logic [20:1] a);
        return {1'b0, a[19], a[17:9]};
    endfunction

    function automatic logic [10:0] cpuColOf(input logic [20:1] a);
        return {3'b000, a[18], a[8:2]};
    endfunction

    task automatic issueCpu(input logic [20:1] addr, input logic isRead);
        @(posedge C1);
        cpuAddr   <= addr;
        rnw       <= isRead;
        tsN       <= 1'b0;
        ramSpaceN <= 1'b0;
        @(posedge C1);
        tsN       <= 1'b1;
        ramSpaceN <= 1'b1;
    endtask

    // Agnus row then column strobes, each held past the synchronizer
    task automatic driveDma(input logic [9:0] row, input logic [9:0] col,
                            input logic useRas1, input logic aweLevel);
        @(posedge C1);
        dra   <= row;
        ras0N <= useRas1;
        ras1N <= ~useRas1;
        repeat (4) @(posedge C1);
        dra   <= col;
        aweN  <= aweLevel;
        caslN <= 1'b0;
        casuN <= 1'b0;
        // Agnus lets go of the bus with the column strobe
        dbrN  <= 1'b1;
        repeat (4) @(posedge C1);
        caslN <= 1'b1;
        casuN <= 1'b1;
        ras0N <= 1'b1;
        ras1N <= 1'b1;
        aweN  <= 1'b1;
    endtask

    // Walks one access from the activate cycle to the flag drop
    task automatic checkAccessCycle(input logic [10:0] expRow, input logic [10:0] expCol,
                                    input logic isWrite, input logic isCpu,
                                    input logic expDbenN, input logic expDbdir);
        sdramCmdT expCmd;
        logic expTack;
        for (int k = 1; k <= 8; k++) begin
            if (k > 1) begin
                @(negedge C1);
            end
            expCmd = cmdNop;
            if (k == 1) expCmd = cmdBankActivate;
            if (k == 3) expCmd = isWrite ? cmdWrite : cmdRead;
            if (k == 4) expCmd = cmdPrecharge;
            checkCmd($sformatf("access step %0d command", k), currentCmd(), expCmd);
            if (k == 1) checkAddr("activate row", cma, expRow);
            if (k == 3) checkAddr("column", cma, expCol);
            if (k == 3) checkBit("weN", weN, ~isWrite);
            if (k == 4) checkAddr("precharge address", cma, expPrechargeAddr);
            // Writes ack right after activate, reads after CAS latency
            expTack = isCpu && (isWrite ? (k == 2) : (k == 6));
            checkBit($sformatf("cpuTack step %0d", k), cpuTack, expTack);
            checkBit($sformatf("clkEn step %0d", k), clkEn, !(!isWrite && k == 6));
            checkBit("cpuCycle", cpuCycle, isCpu && k < 8);
            checkBit("dmaCycle", dmaCycle, !isCpu && k < 8);
            checkBit("dbenN", dbenN, (k < 8) ? expDbenN : 1'b1);
            if (k < 8) checkBit("dbdir", dbdir, expDbdir);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic powerUpTest();
        sdramCmdT expCmd [4];
        sdramCmdT seen;
        int index;
        int waited;
        expCmd = '{cmdPrecharge, cmdModeRegister, cmdAutoRefresh, cmdAutoRefresh};
        index = 0;
        waited = 0;
        while (index < 4 && waited < 60) begin
            @(negedge C1);
            waited++;
            seen = currentCmd();
            if (seen != cmdNop) begin
                checkCmd($sformatf("power-up command %0d", index), seen, expCmd[index]);
                if (index == 0) checkAddr("power-up precharge", cma, expPrechargeAddr);
                if (index == 1) checkAddr("mode word", cma, expModeWord);
                index++;
            end
        end
        if (index < 4) begin
            $display("Timeout: power-up stopped after %0d commands", index);
            timeoutErrors++;
        end
    endtask

    task automatic cpuReadTest();
        logic [20:1] addr;
        bit found;
        addr = 20'($urandom);
        issueCpu(addr, 1'b1);
        waitCmd(cmdBankActivate, accessTimeout, found);
        if (found) checkAccessCycle(cpuRowOf(addr), cpuColOf(addr), 1'b0, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic cpuWriteTest();
        logic [20:1] addr;
        bit found;
        addr = 20'($urandom);
        @(posedge C1);
        dbrN <= 1'b0;
        repeat (3) @(posedge C1);
        issueCpu(addr, 1'b0);
        // Agnus still owns the bus, so no activate may appear
        for (int i = 0; i < 20; i++) begin
            @(negedge C1);
            if (currentCmd() == cmdBankActivate) begin
                $display("CPU cycle started at %0t while Agnus held the bus", $time);
                valueErrors++;
            end
        end
        @(posedge C1);
        dbrN <= 1'b1;
        waitCmd(cmdBankActivate, accessTimeout, found);
        if (found) checkAccessCycle(cpuRowOf(addr), cpuColOf(addr), 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic dmaTest();
        logic [9:0] row;
        logic [9:0] col;
        logic useRas1;
        logic aweLevel;
        logic [20:1] addr;
        bit found;
        row = 10'($urandom);
        col = 10'($urandom);
        useRas1 = 1'($urandom);
        aweLevel = 1'($urandom);
        addr = 20'($urandom);
        // CPU request parks behind the bus request until the DMA shows up
        @(posedge C1);
        dbrN <= 1'b0;
        repeat (3) @(posedge C1);
        issueCpu(addr, 1'b1);
        driveDma(row, col, useRas1, aweLevel);
        waitCmd(cmdBankActivate, accessTimeout, found);
        if (!found) return;
        checkBit("DMA served before CPU", dmaCycle, 1'b1);
        checkAccessCycle({1'b0, useRas1, row[8:0]}, {3'b000, col[8:1]}, ~aweLevel, 1'b0,
                         ~col[0], aweLevel);
        waitCmd(cmdBankActivate, accessTimeout, found);
        if (found) checkAccessCycle(cpuRowOf(addr), cpuColOf(addr), 1'b0, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic refreshTest();
        int firstAt;
        int secondAt;
        int activateAt;
        logic [20:1] addr;
        bit found;
        waitCmd(cmdAutoRefresh, 3 * refreshInterval, found);
        if (!found) return;
        firstAt = cycleCount;
        waitCmd(cmdAutoRefresh, 3 * refreshInterval, found);
        if (!found) return;
        secondAt = cycleCount;
        if (secondAt - firstAt < refreshInterval || secondAt - firstAt > refreshInterval + 10) begin
            $display("FAILED %0t: refresh gap of %0d cycles", $time, secondAt - firstAt);
            valueErrors++;
        end
        // Start a read so that the next refresh falls due inside it
        repeat (refreshInterval - 6) @(posedge C1);
        addr = 20'($urandom);
        issueCpu(addr, 1'b1);
        waitCmd(cmdBankActivate, accessTimeout, found);
        if (!found) return;
        activateAt = cycleCount;
        if (activateAt - secondAt >= refreshInterval) begin
            $display("Read started after the refresh was due, window missed");
            valueErrors++;
        end
        checkAccessCycle(cpuRowOf(addr), cpuColOf(addr), 1'b0, 1'b1, 1'b1, 1'b1);
        waitCmd(cmdAutoRefresh, 20, found);
        if (found && (cycleCount - activateAt < 8 || cycleCount - activateAt > 12)) begin
            $display("FAILED %0t: refresh %0d cycles after activate", $time,
                     cycleCount - activateAt);
            valueErrors++;
        end
    endtask

    initial begin
        void'($urandom(19));
        REFRESH_RST = 1'b1;
        tsN = 1'b1;
        ramSpaceN = 1'b1;
        rnw = 1'b1;
        cpuAddr = '0;
        ras0N = 1'b1;
        ras1N = 1'b1;
        caslN = 1'b1;
        casuN = 1'b1;
        dbrN = 1'b1;
        aweN = 1'b1;
        dra = '0;
        repeat (4) @(posedge C1);
        REFRESH_RST <= 1'b0;
        powerUpTest();
        cpuReadTest();
        cpuWriteTest();
        dmaTest();
        refreshTest();
        repeat (5) @(posedge C1);
        $display("Checks done: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
chipRamPkg.sv
refreshTimer.sv
agnusCapture.sv
accessArbiter.sv
sdramSequencer.sv
chipRamTop.sv
chipRam_assertions.sv
tb_chipRam.sv

/* Makefile */
# Verilator build and run for the chip RAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_chipRam
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD_DIR)/V$(TOP)
PASS_MSG := === PASS ===

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q -- '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
